// ==== compile.f ====
+incdir+hw
hw/ppu_pkg.sv
hw/ppu_regs.sv
hw/ppu_vram.sv
hw/ppu_fetcher.sv
hw/ppu_bg_fifo.sv
hw/ppu_pixel_out.sv
hw/ppu_top.sv
test/ppu_assert.sv
test/ppu_tb.sv

// ==== hw/ppu_bg_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ppu_settings.svh"

module ppu_bg_fifo (
  input  logic                clk,
  input  logic                reset,
  input  logic                line_start,
  input  logic                push,
  input  ppu_pkg::ppu_pixel_t push_px,
  input  logic                pop,
  output ppu_pkg::ppu_pixel_t head_px,
  output logic                empty
);
  import ppu_pkg::*;

  localparam int DEPTH = `PPU_FIFO_DEPTH;
  localparam int PW    = $clog2(DEPTH);

  ppu_pixel_t    mem [DEPTH];
  logic [PW-1:0] wr_ptr;
  logic [PW-1:0] rd_ptr;
  logic [PW:0]   count;
  logic          full;
  logic          wr_en;
  logic          rd_en;

  assign empty   = count == '0;
  assign full    = count == (PW+1)'(DEPTH);
  assign wr_en   = push && !full;
  assign rd_en   = pop && !empty;

  // head is read straight out of the array
  assign head_px = mem[rd_ptr];

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else if (line_start) begin
      // leftovers of the last line are dropped
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) wr_ptr <= wr_ptr + 1'b1;
      if (rd_en) rd_ptr <= rd_ptr + 1'b1;
      // simultaneous push and pop leaves count alone
      count <= count + (PW+1)'(wr_en) - (PW+1)'(rd_en);
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) mem[wr_ptr] <= push_px;
  end

endmodule

`default_nettype wire

// ==== hw/ppu_fetcher.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ppu_settings.svh"

module ppu_fetcher (
  input  logic                clk,
  input  logic                reset,
  input  ppu_pkg::ppu_regs_t  regs,
  input  logic                line_start,
  input  logic                line_done,
  input  logic [7:0]          vram_rdata,
  input  logic                fifo_empty,
  output ppu_pkg::vram_req_t  vram_req,
  output logic                push,
  output ppu_pkg::ppu_pixel_t push_px
);
  import ppu_pkg::*;

  // 160 pixels plus up to 7 fine-scroll pixels
  localparam int TILES_PER_LINE = 21;

  localparam logic [15:0] MAP_9800  = 16'h9800;
  localparam logic [15:0] MAP_9C00  = 16'h9C00;
  localparam logic [15:0] DATA_8000 = 16'h8000;
  localparam logic [15:0] DATA_9000 = 16'h9000;

  typedef enum logic [2:0] {
    S_GET_TILE,
    S_GET_LO,
    S_GET_HI,
    S_SLEEP,
    S_PUSH
  } fstate_t;

  typedef enum logic {
    PHASE_0,
    PHASE_1
  } phase_t;

  fstate_t            state;
  phase_t             phase;
  logic               active;
  logic [4:0]         tile_n;
  logic [2:0]         push_i;
  tile_id_u           tile_id;
  logic [7:0]         lo_q;
  logic [7:0]         hi_q;
  logic [7:0]         bg_y;
  logic [4:0]         tile_col;
  logic [15:0]        map_addr;
  logic [15:0]        tile_off;
  logic [15:0]        row_addr;
  logic [VRAM_AW-1:0] map_off;
  logic [VRAM_AW-1:0] row_off;
  logic               run;
  logic               sample;
  logic               push_go;

  // background row for this scanline, wraps at 256
  assign bg_y = regs.scy + regs.ly;

  // 5-bit add gives the column wrap at 31
  assign tile_col = regs.scx[7:3] + tile_n;
  assign map_addr = (regs.lcdc[3] ? MAP_9C00 : MAP_9800) + {6'b0, bg_y[7:3], tile_col};

  // 16 bytes per tile, index read in the view lcdc bit 4 asks for
  always_comb begin
    if (regs.lcdc[4]) begin
      tile_off = {4'b0, tile_id.idx_u, 4'b0};
    end else begin
      tile_off = {{4{tile_id.idx_s[7]}}, tile_id.idx_s, 4'b0};
    end
  end

  // two bytes per pixel row inside the tile
  assign row_addr = (regs.lcdc[4] ? DATA_8000 : DATA_9000) + tile_off
                  + {12'b0, bg_y[2:0], 1'b0};

  assign map_off = VRAM_AW'(map_addr - `PPU_VRAM_BASE);
  assign row_off = VRAM_AW'(row_addr - `PPU_VRAM_BASE);

  assign run = active && !line_done;

  // second dot of a read state, data from last cycle's request is on the bus
  assign sample = run && phase == PHASE_1
               && (state == S_GET_TILE || state == S_GET_LO || state == S_GET_HI);

  // first pixel waits for an empty fifo, the other seven follow back to back
  assign push_go = run && state == S_PUSH && (push_i != 3'd0 || fifo_empty);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state    <= S_GET_TILE;
      phase    <= PHASE_0;
      active   <= 1'b0;
      tile_n   <= 5'd0;
      push_i   <= 3'd0;
      push     <= 1'b0;
      vram_req <= '0;
    end else if (line_start) begin
      state       <= S_GET_TILE;
      phase       <= PHASE_0;
      active      <= 1'b1;
      tile_n      <= 5'd0;
      push_i      <= 3'd0;
      push        <= 1'b0;
      vram_req.rd <= 1'b0;
    end else if (!run) begin
      // line over or never started
      active      <= 1'b0;
      push        <= 1'b0;
      vram_req.rd <= 1'b0;
    end else begin
      push        <= push_go;
      vram_req.rd <= 1'b0;
      case (state)
        S_GET_TILE: begin
          if (phase == PHASE_0) begin
            vram_req <= '{rd: 1'b1, addr: map_off};
            phase    <= PHASE_1;
          end else begin
            phase <= PHASE_0;
            state <= S_GET_LO;
          end
        end
        S_GET_LO: begin
          if (phase == PHASE_0) begin
            vram_req <= '{rd: 1'b1, addr: row_off};
            phase    <= PHASE_1;
          end else begin
            phase <= PHASE_0;
            state <= S_GET_HI;
          end
        end
        S_GET_HI: begin
          // high bitplane sits right after the low one
          if (phase == PHASE_0) begin
            vram_req <= '{rd: 1'b1, addr: row_off + VRAM_AW'(1)};
            phase    <= PHASE_1;
          end else begin
            phase <= PHASE_0;
            state <= S_SLEEP;
          end
        end
        S_SLEEP: begin
          if (phase == PHASE_0) begin
            phase <= PHASE_1;
          end else begin
            phase <= PHASE_0;
            state <= S_PUSH;
          end
        end
        S_PUSH: begin
          if (push_go) begin
            push_i <= push_i + 3'd1;
            if (push_i == 3'd7) begin
              state <= S_GET_TILE;
              if (tile_n == 5'(TILES_PER_LINE - 1)) begin
                active <= 1'b0;
              end else begin
                tile_n <= tile_n + 5'd1;
              end
            end
          end
        end
        default: state <= S_GET_TILE;
      endcase
    end
  end

  // tile bytes and the outgoing pixel
  always_ff @(posedge clk) begin
    if (sample) begin
      case (state)
        S_GET_TILE: tile_id.idx_u <= vram_rdata;
        S_GET_LO:   lo_q          <= vram_rdata;
        S_GET_HI:   hi_q          <= vram_rdata;
        default: ;
      endcase
    end
    if (push_go) begin
      // leftmost pixel is bit 7 of both planes
      push_px <= '{color: {hi_q[7], lo_q[7]}, valid: 1'b1};
      lo_q    <= {lo_q[6:0], 1'b0};
      hi_q    <= {hi_q[6:0], 1'b0};
    end
  end

endmodule

`default_nettype wire

// ==== hw/ppu_pixel_out.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ppu_settings.svh"

module ppu_pixel_out (
  input  logic                clk,
  input  logic                reset,
  input  ppu_pkg::ppu_regs_t  regs,
  input  logic                line_start,
  input  ppu_pkg::ppu_pixel_t head_px,
  input  logic                fifo_empty,
  output logic                pop,
  output logic                pix_valid,
  output logic [7:0]          pix_x,
  output logic [1:0]          pix_shade,
  output logic                line_done
);

  localparam logic [7:0] LAST_X = 8'(`PPU_LINE_PIXELS - 1);

  logic       running;
  logic [2:0] drop_cnt;
  logic [7:0] x_cnt;
  logic       show;

  // drain one pixel every cycle something is there
  assign pop  = running && !fifo_empty;

  // popped pixel survives the fine-scroll discard
  assign show = pop && drop_cnt == 3'd0 && head_px.valid;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      running   <= 1'b0;
      drop_cnt  <= 3'd0;
      x_cnt     <= 8'd0;
      pix_valid <= 1'b0;
      line_done <= 1'b0;
    end else begin
      pix_valid <= show;
      // one cycle after the last visible pixel
      line_done <= pix_valid && pix_x == LAST_X;
      if (line_start) begin
        running  <= 1'b1;
        drop_cnt <= regs.scx[2:0];
        x_cnt    <= 8'd0;
      end else if (pop) begin
        if (drop_cnt != 3'd0) begin
          drop_cnt <= drop_cnt - 3'd1;
        end else if (show) begin
          x_cnt <= x_cnt + 8'd1;
          // stop right after popping pixel 159
          if (x_cnt == LAST_X) running <= 1'b0;
        end
      end
    end
  end

  // bgp holds four 2-bit shades, color c picks bits 2c+1:2c
  always_ff @(posedge clk) begin
    if (show) begin
      pix_x     <= x_cnt;
      pix_shade <= regs.bgp[{head_px.color, 1'b0} +: 2];
    end
  end

endmodule

`default_nettype wire

// ==== hw/ppu_pkg.sv ====
`default_nettype none

`include "ppu_settings.svh"

package ppu_pkg;

  // offset width inside vram
  localparam int VRAM_AW = $clog2(`PPU_VRAM_WORDS);

  // register set seen by the render pipeline
  typedef struct packed {
    logic [7:0] lcdc;
    logic [7:0] scy;
    logic [7:0] scx;
    logic [7:0] ly;
    logic [7:0] bgp;
  } ppu_regs_t;

  // one background pixel as it moves through the fifo
  typedef struct packed {
    logic [1:0] color;
    logic       valid;
  } ppu_pixel_t;

  // tile map byte, read unsigned for 8000h data or signed for 9000h data
  typedef union packed {
    logic        [7:0] idx_u;
    logic signed [7:0] idx_s;
  } tile_id_u;

  // fetcher read request into vram
  typedef struct packed {
    logic               rd;
    logic [VRAM_AW-1:0] addr;
  } vram_req_t;

endpackage

`default_nettype wire

// ==== hw/ppu_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ppu_settings.svh"

module ppu_regs (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        psel,
  input  logic                        penable,
  input  logic                        pwrite,
  input  logic [15:0]                 paddr,
  input  logic [7:0]                  pwdata,
  input  logic                        line_done,
  output logic [7:0]                  prdata,
  output logic                        pready,
  output logic                        pslverr,
  output ppu_pkg::ppu_regs_t          regs,
  output logic                        line_start,
  output logic                        busy,
  output logic                        cpu_we,
  output logic [ppu_pkg::VRAM_AW-1:0] cpu_addr,
  output logic [7:0]                  cpu_wdata,
  input  logic [7:0]                  cpu_rdata
);
  import ppu_pkg::*;

  // lines 0..143 are the visible ones
  localparam int VISIBLE_LINES = 144;

  logic        access;
  logic        vram_hit;
  logic [15:0] vram_off;
  logic        reg_wr;
  logic        line_go;

  // apb access phase, always zero wait states
  assign access = psel && penable;
  assign pready = access;

  // addresses below the base wrap to a large offset and miss too
  assign vram_off = paddr - `PPU_VRAM_BASE;
  assign vram_hit = vram_off < `PPU_VRAM_WORDS;

  // cpu path into vram, only honored while idle
  assign cpu_addr  = vram_off[VRAM_AW-1:0];
  assign cpu_wdata = pwdata;
  assign cpu_we    = access && pwrite && vram_hit && !busy;

  // vram touched mid-line, or stat written
  assign pslverr = access && ((vram_hit && busy) || (pwrite && paddr == `PPU_REG_STAT));

  // render registers are frozen while a line runs
  assign reg_wr  = access && pwrite && !busy;
  assign line_go = reg_wr && paddr == `PPU_REG_LY && pwdata < 8'(VISIBLE_LINES);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      regs       <= '0;
      busy       <= 1'b0;
      line_start <= 1'b0;
    end else begin
      line_start <= line_go;
      if (line_go) begin
        busy    <= 1'b1;
        regs.ly <= pwdata;
      end else if (line_done) begin
        busy <= 1'b0;
      end
      if (reg_wr) begin
        case (paddr)
          `PPU_REG_LCDC: regs.lcdc <= pwdata;
          `PPU_REG_SCY:  regs.scy  <= pwdata;
          `PPU_REG_SCX:  regs.scx  <= pwdata;
          `PPU_REG_BGP:  regs.bgp  <= pwdata;
          default: ;
        endcase
      end
    end
  end

  // read mux, unmapped space and busy vram read as zero
  always_comb begin
    prdata = 8'h00;
    if (vram_hit) begin
      if (!busy) prdata = cpu_rdata;
    end else begin
      case (paddr)
        `PPU_REG_LCDC: prdata = regs.lcdc;
        `PPU_REG_STAT: prdata = {7'b0, busy};
        `PPU_REG_SCY:  prdata = regs.scy;
        `PPU_REG_SCX:  prdata = regs.scx;
        `PPU_REG_LY:   prdata = regs.ly;
        `PPU_REG_BGP:  prdata = regs.bgp;
        default:       prdata = 8'h00;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== hw/ppu_settings.svh ====
`ifndef PPU_SETTINGS_SVH
`define PPU_SETTINGS_SVH

// vram window on the cpu bus, 8 KiB of bytes
`define PPU_VRAM_BASE   16'h8000
`define PPU_VRAM_WORDS  8192

// lcd register addresses
`define PPU_REG_LCDC    16'hFF40
`define PPU_REG_STAT    16'hFF41
`define PPU_REG_SCY     16'hFF42
`define PPU_REG_SCX     16'hFF43
`define PPU_REG_LY      16'hFF44
`define PPU_REG_BGP     16'hFF47

// background fifo size in pixels
`define PPU_FIFO_DEPTH  16

// visible pixels per scanline
`define PPU_LINE_PIXELS 160

`endif

// ==== hw/ppu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module ppu_top (
  input  logic        clk,
  input  logic        reset,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [15:0] paddr,
  input  logic [7:0]  pwdata,
  output logic [7:0]  prdata,
  output logic        pready,
  output logic        pslverr,
  output logic        pix_valid,
  output logic [7:0]  pix_x,
  output logic [1:0]  pix_shade,
  output logic        irq_line_done
);
  import ppu_pkg::*;

  ppu_regs_t          regs;
  logic               line_start;
  logic               line_done;
  logic               busy;
  logic               cpu_we;
  logic [VRAM_AW-1:0] cpu_addr;
  logic [7:0]         cpu_wdata;
  logic [7:0]         vram_rdata;
  vram_req_t          vram_req;
  logic               push;
  ppu_pixel_t         push_px;
  logic               pop;
  ppu_pixel_t         head_px;
  logic               fifo_empty;

  assign irq_line_done = line_done;

  ppu_regs u_regs (
    .clk        (clk),
    .reset      (reset),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .paddr      (paddr),
    .pwdata     (pwdata),
    .line_done  (line_done),
    .prdata     (prdata),
    .pready     (pready),
    .pslverr    (pslverr),
    .regs       (regs),
    .line_start (line_start),
    .busy       (busy),
    .cpu_we     (cpu_we),
    .cpu_addr   (cpu_addr),
    .cpu_wdata  (cpu_wdata),
    .cpu_rdata  (vram_rdata)
  );

  ppu_vram u_vram (
    .clk       (clk),
    .busy      (busy),
    .req       (vram_req),
    .cpu_we    (cpu_we),
    .cpu_addr  (cpu_addr),
    .cpu_wdata (cpu_wdata),
    .rdata     (vram_rdata)
  );

  // pipeline: fetcher, fifo, pixel output
  ppu_fetcher u_fetcher (
    .clk        (clk),
    .reset      (reset),
    .regs       (regs),
    .line_start (line_start),
    .line_done  (line_done),
    .vram_rdata (vram_rdata),
    .fifo_empty (fifo_empty),
    .vram_req   (vram_req),
    .push       (push),
    .push_px    (push_px)
  );

  ppu_bg_fifo u_bg_fifo (
    .clk        (clk),
    .reset      (reset),
    .line_start (line_start),
    .push       (push),
    .push_px    (push_px),
    .pop        (pop),
    .head_px    (head_px),
    .empty      (fifo_empty)
  );

  ppu_pixel_out u_pixel_out (
    .clk        (clk),
    .reset      (reset),
    .regs       (regs),
    .line_start (line_start),
    .head_px    (head_px),
    .fifo_empty (fifo_empty),
    .pop        (pop),
    .pix_valid  (pix_valid),
    .pix_x      (pix_x),
    .pix_shade  (pix_shade),
    .line_done  (line_done)
  );

endmodule

`default_nettype wire

// ==== hw/ppu_vram.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ppu_settings.svh"

module ppu_vram (
  input  logic                        clk,
  input  logic                        busy,
  input  ppu_pkg::vram_req_t          req,
  input  logic                        cpu_we,
  input  logic [ppu_pkg::VRAM_AW-1:0] cpu_addr,
  input  logic [7:0]                  cpu_wdata,
  output logic [7:0]                  rdata
);
  import ppu_pkg::*;

  logic [7:0]         mem [`PPU_VRAM_WORDS];
  logic [VRAM_AW-1:0] addr;

  // single port, the fetcher owns it for the whole line
  assign addr = busy ? req.addr : cpu_addr;

  always_ff @(posedge clk) begin
    if (cpu_we && !busy) begin
      mem[addr] <= cpu_wdata;
    end
  end

  // async read
  // fetcher side is quiet between its reads
  assign rdata = (busy && !req.rd) ? 8'h00 : mem[addr];

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# build the ppu testbench with verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module ppu_tb -f compile.f -o ppu_sim \
  && { ./obj_dir/ppu_sim > sim.log 2>&1; status=$?; cat sim.log; [ "$status" -eq 0 ]; } \
  && ! grep -q "Something failed" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// ==== test/ppu_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ppu_settings.svh"

module ppu_assert (
  input logic               clk,
  input logic               reset,
  input logic               psel,
  input logic               penable,
  input logic               pready,
  input logic               pix_valid,
  input logic [7:0]         pix_x,
  input logic               line_start,
  input logic               push,
  input logic               pop,
  input logic               busy,
  input ppu_pkg::vram_req_t vram_req
);
  import ppu_pkg::*;

  localparam int         DEPTH  = `PPU_FIFO_DEPTH;
  localparam logic [7:0] LAST_X = 8'(`PPU_LINE_PIXELS - 1);

  // fifo fill level rebuilt from push and pop
  logic [$clog2(DEPTH):0] occ;
  logic [7:0]             last_x;
  logic                   seen_px;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      occ     <= '0;
      last_x  <= 8'd0;
      seen_px <= 1'b0;
    end else begin
      if (line_start) occ <= '0;
      else occ <= occ + ($clog2(DEPTH)+1)'(push) - ($clog2(DEPTH)+1)'(pop);
      if (pix_valid) begin
        last_x  <= pix_x;
        seen_px <= 1'b1;
      end
    end
  end

  a_pready: assert property (@(posedge clk) disable iff (reset)
    psel && penable |-> pready)
    else $error("apb access phase without pready");

  // 159 is followed by 0 of the next line
  a_pix_x: assert property (@(posedge clk) disable iff (reset)
    pix_valid && seen_px |-> pix_x == ((last_x == LAST_X) ? 8'd0 : last_x + 8'd1))
    else $error("pix_x did not step by one");

  a_no_full_push: assert property (@(posedge clk) disable iff (reset)
    push |-> occ < ($clog2(DEPTH)+1)'(DEPTH))
    else $error("push into a full background fifo");

  a_idle_rd: assert property (@(posedge clk) disable iff (reset)
    !busy |-> !vram_req.rd)
    else $error("fetcher read vram while idle");

endmodule

bind ppu_top ppu_assert i_assert (
  .clk        (clk),
  .reset      (reset),
  .psel       (psel),
  .penable    (penable),
  .pready     (pready),
  .pix_valid  (pix_valid),
  .pix_x      (pix_x),
  .line_start (line_start),
  .push       (push),
  .pop        (pop),
  .busy       (busy),
  .vram_req   (vram_req)
);

`default_nettype wire

// ==== test/ppu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ppu_settings.svh"

module ppu_tb;
  import ppu_pkg::*;

  // a line ends within 21 x 24 + 10 cycles of the LY write
  localparam int LINE_CYCLES = 530;
  localparam int N_LINES     = 9;
  localparam int N_READBACK  = 64;
  // vram fill, readback and register traffic, 2 cycles per transfer
  localparam int APB_OPS     = `PPU_VRAM_WORDS + N_READBACK + 200;
  localparam int CYCLE_LIMIT = N_LINES * LINE_CYCLES + 2 * APB_OPS + 500;

  logic        clk;
  logic        reset;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [15:0] paddr;
  logic [7:0]  pwdata;
  logic [7:0]  prdata;
  logic        pready;
  logic        pslverr;
  logic        pix_valid;
  logic [7:0]  pix_x;
  logic [1:0]  pix_shade;
  logic        irq_line_done;

  // mirror of vram and of the render registers
  logic [7:0]  vram_model [`PPU_VRAM_WORDS];
  logic [7:0]  m_lcdc;
  logic [7:0]  m_scy;
  logic [7:0]  m_scx;
  logic [7:0]  m_ly;
  logic [7:0]  m_bgp;
  logic [15:0] lfsr_state;
  int          err_value;
  int          err_other;
  int          cycle_cnt;
  int          high_idx_hits;

  ppu_top i_dut (
    .clk           (clk),
    .reset         (reset),
    .psel          (psel),
    .penable       (penable),
    .pwrite        (pwrite),
    .paddr         (paddr),
    .pwdata        (pwdata),
    .prdata        (prdata),
    .pready        (pready),
    .pslverr       (pslverr),
    .pix_valid     (pix_valid),
    .pix_x         (pix_x),
    .pix_shade     (pix_shade),
    .irq_line_done (irq_line_done)
  );

  always #20 clk = ~clk;

  // watchdog over the whole run
  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("timeout: the run did not end within %0d cycles", CYCLE_LIMIT);
      $display("Something failed");
      $finish;
    end
  end

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    if (actual !== expected) begin
      $display("error: time %0d ns, %s expected %0h, got %0h", $time, name, expected, actual);
      err_value++;
    end
  endtask

  task automatic report_failure(input string what);
    $display("failure at time %0d ns: %s", $time, what);
    err_other++;
  endtask

  // x^16 + x^14 + x^13 + x^11 + 1, one step per bit
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
    lfsr_state = {lfsr_state[14:0], fb};
    return fb;
  endfunction

  function automatic logic [7:0] rand_byte();
    logic [7:0] b;
    b = 8'h00;
    for (int i = 0; i < 8; i++) begin
      b = {b[6:0], lfsr_bit()};
    end
    return b;
  endfunction

  // map byte under screen pixel x of the current line
  function automatic tile_id_u map_entry(input int x);
    tile_id_u id;
    int       bg_x;
    int       bg_y;
    int       map_off;
    bg_x = (int'(m_scx) + x) % 256;
    bg_y = (int'(m_scy) + int'(m_ly)) % 256;
    map_off = (m_lcdc[3] ? 'h1C00 : 'h1800) + (bg_y / 8) * 32 + bg_x / 8;
    id.idx_u = vram_model[map_off];
    return id;
  endfunction

  // expected shade of screen pixel x
  function automatic logic [1:0] model_shade(input int x);
    tile_id_u   id;
    int         bg_x;
    int         fine_y;
    int         row_off;
    int         bitpos;
    logic [7:0] lo;
    logic [7:0] hi;
    logic [1:0] color;
    id = map_entry(x);
    bg_x = (int'(m_scx) + x) % 256;
    fine_y = (int'(m_scy) + int'(m_ly)) % 8;
    // 8000h with unsigned index, else 9000h with signed index
    if (m_lcdc[4]) row_off = 16 * int'(id.idx_u);
    else row_off = 'h1000 + 16 * int'(id.idx_s);
    row_off = row_off + 2 * fine_y;
    lo = vram_model[row_off];
    hi = vram_model[row_off + 1];
    bitpos = 7 - bg_x % 8;
    color = {hi[bitpos], lo[bitpos]};
    return m_bgp[2 * int'(color) +: 2];
  endfunction

  // one transfer, entered and left 2 ns after a rising edge
  task automatic apb_access(input logic wr, input logic [15:0] addr, input logic [7:0] wdata,
                            output logic [7:0] rdata, output logic err);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(posedge clk);
    #2;
    penable = 1'b1;
    // sample mid cycle, well away from the edge
    #10;
    check("pready", 1, pready);
    rdata = prdata;
    err   = pslverr;
    @(posedge clk);
    #2;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_write(input logic [15:0] addr, input logic [7:0] data, input logic exp_err);
    logic [7:0] d;
    logic       err;
    apb_access(1'b1, addr, data, d, err);
    check("pslverr", exp_err, err);
  endtask

  task automatic apb_read(input logic [15:0] addr, output logic [7:0] data,
                          input logic exp_err);
    logic err;
    apb_access(1'b0, addr, 8'h00, data, err);
    check("pslverr", exp_err, err);
  endtask

  task automatic expect_read(input logic [15:0] addr, input logic [7:0] exp, input string name);
    logic [7:0] d;
    apb_read(addr, d, 1'b0);
    check(name, exp, d);
  endtask

  task automatic set_render(input logic [7:0] lcdc, input logic [7:0] scy,
                            input logic [7:0] scx, input logic [7:0] bgp);
    apb_write(`PPU_REG_LCDC, lcdc, 1'b0);
    apb_write(`PPU_REG_SCY, scy, 1'b0);
    apb_write(`PPU_REG_SCX, scx, 1'b0);
    apb_write(`PPU_REG_BGP, bgp, 1'b0);
    m_lcdc = lcdc;
    m_scy  = scy;
    m_scx  = scx;
    m_bgp  = bgp;
  endtask

  task automatic start_line(input logic [7:0] ly);
    m_ly = ly;
    apb_write(`PPU_REG_LY, ly, 1'b0);
  endtask

  // gather the 160 pixels until irq_line_done
  task automatic collect_line();
    tile_id_u id;
    int       n;
    int       waited;
    logic     done;
    n = 0;
    waited = 0;
    done = 1'b0;
    while (!done && waited < LINE_CYCLES) begin
      @(posedge clk);
      #2;
      waited++;
      if (pix_valid) begin
        if (n < `PPU_LINE_PIXELS) begin
          check("pix_x", n, pix_x);
          check("pix_shade", model_shade(n), pix_shade);
          id = map_entry(n);
          if (!m_lcdc[4] && id.idx_s < 0) high_idx_hits++;
        end else begin
          report_failure("more than 160 pixels in one line");
        end
        n++;
      end
      if (irq_line_done) done = 1'b1;
    end
    if (!done) begin
      report_failure("irq_line_done did not arrive");
    end else begin
      check("pixel count", `PPU_LINE_PIXELS, n);
      // single cycle pulse
      @(posedge clk);
      #2;
      check("irq_line_done", 0, irq_line_done);
    end
  endtask

  task automatic check_idle();
    expect_read(`PPU_REG_STAT, 8'h00, "stat");
  endtask

  task automatic render(input logic [7:0] ly);
    start_line(ly);
    collect_line();
    check_idle();
    // the started line number stays readable
    expect_read(`PPU_REG_LY, ly, "ly");
  endtask

  // bus accesses that must bounce while a line runs
  task automatic probe_while_busy(input int off);
    logic [7:0] d;
    apb_write(16'(`PPU_VRAM_BASE + off), ~vram_model[off], 1'b1);
    apb_read(16'(`PPU_VRAM_BASE + off), d, 1'b1);
    apb_write(`PPU_REG_STAT, 8'h00, 1'b1);
    apb_read(`PPU_REG_STAT, d, 1'b0);
    check("stat", 8'h01, d);
  endtask

  task automatic reset_and_regs();
    check("pready", 0, pready);
    check("pslverr", 0, pslverr);
    check("pix_valid", 0, pix_valid);
    check("irq_line_done", 0, irq_line_done);
    expect_read(`PPU_REG_LCDC, 8'h00, "lcdc");
    expect_read(`PPU_REG_STAT, 8'h00, "stat");
    expect_read(`PPU_REG_SCY, 8'h00, "scy");
    expect_read(`PPU_REG_SCX, 8'h00, "scx");
    expect_read(`PPU_REG_LY, 8'h00, "ly");
    expect_read(`PPU_REG_BGP, 8'h00, "bgp");
    set_render(8'h91, 8'h12, 8'h34, 8'hE4);
    expect_read(`PPU_REG_LCDC, 8'h91, "lcdc");
    expect_read(`PPU_REG_SCY, 8'h12, "scy");
    expect_read(`PPU_REG_SCX, 8'h34, "scx");
    expect_read(`PPU_REG_BGP, 8'hE4, "bgp");
    // stat is read only
    apb_write(`PPU_REG_STAT, 8'h01, 1'b1);
    expect_read(`PPU_REG_STAT, 8'h00, "stat");
    // line 200 is off screen and starts nothing
    apb_write(`PPU_REG_LY, 8'd200, 1'b0);
    expect_read(`PPU_REG_STAT, 8'h00, "stat");
    expect_read(16'hFF45, 8'h00, "unmapped ff45");
    expect_read(16'hFF48, 8'h00, "unmapped ff48");
    expect_read(16'h7FFF, 8'h00, "unmapped 7fff");
    expect_read(16'hA000, 8'h00, "unmapped a000");
    expect_read(16'h0000, 8'h00, "unmapped 0000");
  endtask

  task automatic vram_access();
    int off;
    for (int a = 0; a < `PPU_VRAM_WORDS; a++) begin
      vram_model[a] = rand_byte();
      apb_write(16'(`PPU_VRAM_BASE + a), vram_model[a], 1'b0);
    end
    for (int i = 0; i < N_READBACK; i++) begin
      off = (i * 131 + 7) % `PPU_VRAM_WORDS;
      expect_read(16'(`PPU_VRAM_BASE + off), vram_model[off], "vram readback");
    end
    set_render(8'h91, 8'h00, 8'h00, 8'hE4);
    start_line(8'd10);
    fork
      collect_line();
      probe_while_busy('h0123);
    join
    check_idle();
    expect_read(16'(`PPU_VRAM_BASE + 'h0123), vram_model['h0123], "vram after busy write");
  endtask

  task automatic unsigned_lines();
    set_render(8'h91, 8'h00, 8'h00, 8'hE4);
    render(8'd0);
    render(8'd77);
  endtask

  task automatic signed_lines();
    high_idx_hits = 0;
    set_render(8'h81, 8'h00, 8'h00, 8'hE4);
    render(8'd3);
    render(8'd100);
    if (high_idx_hits == 0) report_failure("no tile index at or above 80h was rendered");
  endtask

  task automatic scrolled_lines();
    // scx FBh starts at column 31 and wraps to 0
    set_render(8'h91, 8'h9D, 8'hFB, 8'hE4);
    render(8'd50);
    // scy + ly passes 255
    set_render(8'h81, 8'hF0, 8'h07, 8'h6C);
    render(8'd143);
  endtask

  task automatic palette_and_map();
    set_render(8'h99, 8'h00, 8'h00, 8'h1B);
    render(8'd20);
    set_render(8'h89, 8'h40, 8'h2A, 8'h4E);
    render(8'd120);
  endtask

  initial begin
    clk        = 1'b0;
    reset      = 1'b1;
    psel       = 1'b0;
    penable    = 1'b0;
    pwrite     = 1'b0;
    paddr      = 16'h0000;
    pwdata     = 8'h00;
    err_value  = 0;
    err_other  = 0;
    cycle_cnt  = 0;
    lfsr_state = 16'd34735;
    m_lcdc     = 8'h00;
    m_scy      = 8'h00;
    m_scx      = 8'h00;
    m_ly       = 8'h00;
    m_bgp      = 8'h00;
    repeat (4) @(posedge clk);
    #2;
    reset = 1'b0;
    @(posedge clk);
    #2;
    reset_and_regs();
    vram_access();
    unsigned_lines();
    signed_lines();
    scrolled_lines();
    palette_and_map();
    $display("summary: %0d value errors, %0d other errors", err_value, err_other);
    if (err_value == 0 && err_other == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
